// ==== sources.f ====
+incdir+source
source/ttc_pkg.sv
source/ttc_cfg_if.sv
source/ttc_csr_axil.sv
source/ddr3_occupancy.sv
source/ttc_trigger_receiver.sv
source/trig_info_fifo.sv
source/ttc_trigger_top.sv
bench/ttc_trigger_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary -Wno-fatal
TOP       := ttc_trigger_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/ttc_trigger_tb.sv ====
// testbench for the ttc trigger subsystem, checks trigger records against a reference model
`include "ttc_cfg.svh"

module ttc_trigger_tb;
  import ttc_pkg::*;

  localparam int MAX_CYCLES = 4000;  // tests need about 1300 cycles

  logic                 clk;
  logic                 reset;
  logic [`AXI_AW-1:0]   awaddr;
  logic                 awvalid;
  logic                 awready;
  logic [31:0]          wdata;
  logic                 wvalid;
  logic                 wready;
  logic [1:0]           bresp;
  logic                 bvalid;
  logic                 bready;
  logic [`AXI_AW-1:0]   araddr;
  logic                 arvalid;
  logic                 arready;
  logic [31:0]          rdata;
  logic [1:0]           rresp;
  logic                 rvalid;
  logic                 rready;
  logic                 reset_trig_num;
  logic                 reset_trig_timestamp;
  logic                 trigger;
  logic [1:0]           trig_type;
  logic                 acq_ready;
  logic                 acq_trigger;
  logic [1:0]           acq_trig_type;
  logic [`TRIG_W-1:0]   acq_trig_num;
  logic                 readout_done;
  logic [`RO_W-1:0]     readout_size;
  logic                 rec_valid;
  logic                 rec_ready;
  logic [127:0]         rec_data;
  logic                 error_trig_rate;
  logic                 ddr3_overflow_warning;

  // reference model
  logic [`TRIG_W-1:0]   m_trig_num;   // next trigger number
  logic [`TRIG_W-1:0]   m_event_cnt;  // next event number
  longint               m_stored [`NUM_CHAN];
  longint               m_burst [`NUM_CHAN];
  longint               m_wfm [`NUM_CHAN];
  logic [7:0]           m_block;      // blocked trigger types
  logic [`NUM_CHAN-1:0] m_chan_en;
  longint               m_thres;
  logic [31:0]          m_ovf;

  logic [127:0]         exp_q [$];    // records still to come out
  logic                 exp_pass;     // last trigger should reach the channels
  logic [`TRIG_W-1:0]   exp_acq_num;
  logic [1:0]           exp_acq_type;
  logic [127:0]         exp_rec;
  logic [`TS_W-1:0]     last_ts;
  logic                 have_ts;
  int                   cycle_cnt;
  int                   acq_pulses;   // acq_trigger pulses seen
  int                   exp_pulses;   // passed triggers in the model

  ttc_trigger_top ttc_trigger_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    do @(negedge clk); while (!awready);  // address and data taken together
    compare("wready", 1'b1, wready);  // pulses with awready
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(negedge clk); while (!bvalid);
    compare("bresp", 2'b00, bresp);
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do @(negedge clk); while (!rvalid);
    data = rdata;  // stable until the next edge
    compare("rresp", 2'b00, rresp);
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // register write, mirrored into the model
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    axi_write(addr, data);
    if (addr == `ADDR_CTRL) begin
      m_block   = data[7:0];
      m_chan_en = data[12:8];
    end
    if (addr == `ADDR_THRES)
      m_thres = data;
    for (int i = 0; i < `NUM_CHAN; i++) begin
      if (addr == 8'(`ADDR_BURST0 + 4 * i))
        m_burst[i] = data[`BURST_W-1:0];
      if (addr == 8'(`ADDR_WFM0 + 4 * i))
        m_wfm[i] = data[`WFM_W-1:0];
    end
  endtask

  function automatic longint acq_size(input int ch);
    return (m_burst[ch] + 1) * m_wfm[ch] + 2;  // header per waveform, two trailer bursts
  endfunction

  function automatic logic model_full();
    logic full;
    full = 1'b0;
    for (int i = 0; i < `NUM_CHAN; i++)
      if (m_chan_en[i] && (`DDR3_BURSTS - m_stored[i]) < acq_size(i))
        full = 1'b1;
    return full;
  endfunction

  function automatic logic model_warning();
    logic warn;
    warn = 1'b0;
    for (int i = 0; i < `NUM_CHAN; i++)
      if (m_stored[i] > m_thres)
        warn = 1'b1;
    return warn;
  endfunction

  // expected record for one trigger, advances the model
  function automatic logic [127:0] predict_record(input logic [1:0] ttype);
    logic         full;
    logic         empty;
    logic [127:0] rec;
    full  = model_full();
    empty = m_block[ttype] | full;
    rec   = {33'd0, empty, ttype, m_event_cnt, m_trig_num, 44'd0};  // timestamp masked
    if (!m_block[ttype] && full)
      m_ovf = m_ovf + 1;
    if (!empty) begin
      for (int i = 0; i < `NUM_CHAN; i++)
        if (m_chan_en[i])
          m_stored[i] += acq_size(i);
      m_event_cnt = m_event_cnt + 1;
      exp_pulses++;
    end
    m_trig_num = m_trig_num + 1;
    exp_pass   = !empty;
    return rec;
  endfunction

  task automatic wait_idle();
    logic [31:0] st;
    do axi_read(`ADDR_STATUS, st); while (st[3:0] != 4'(st_idle));
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0)
      @(negedge clk);
  endtask

  // one-cycle trigger pulse; expect_record waits for idle and models it
  task automatic fire_trigger(input logic [1:0] ttype, input logic expect_record);
    repeat ($urandom_range(0, 3)) @(posedge clk);  // random gap
    if (expect_record) begin
      wait_idle();
      exp_acq_num  = m_trig_num;
      exp_acq_type = ttype;
      exp_q.push_back(predict_record(ttype));
    end else begin
      exp_pass = 1'b0;
    end
    @(posedge clk);
    trigger   <= 1'b1;
    trig_type <= ttype;
    @(posedge clk);
    trigger   <= 1'b0;
  endtask

  task automatic pulse_readout(input logic [`RO_W-1:0] size);
    @(posedge clk);
    readout_done <= 1'b1;
    readout_size <= size;
    @(posedge clk);
    readout_done <= 1'b0;
    for (int i = 0; i < `NUM_CHAN; i++)
      if (m_chan_en[i])
        m_stored[i] -= size;
  endtask

  // acquisition pulse against the model
  always @(negedge clk) begin
    if (!reset && acq_trigger) begin
      compare("acq_trigger pulse", exp_pass, 1'b1);
      compare("acq_trig_num", exp_acq_num, acq_trig_num);
      compare("acq_trig_type", exp_acq_type, acq_trig_type);
      acq_pulses++;
    end
  end

  // record comparison, one per transfer
  always @(negedge clk) begin
    if (!reset && rec_valid && rec_ready) begin
      if (exp_q.size() == 0) begin
        report_failure("a record came out with no trigger outstanding");
      end else begin
        exp_rec = exp_q.pop_front();
        compare("record fields", exp_rec[127:44], rec_data[127:44]);
        if (have_ts)
          compare("timestamp increases", 1'b1, rec_data[43:0] > last_ts);
        last_ts = rec_data[43:0];
        have_ts = 1'b1;
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    report_failure("timeout, the tests did not finish within the cycle limit");
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] val;
    int          k;
    void'($urandom(58129));
    reset = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    reset_trig_num = 1'b0;
    reset_trig_timestamp = 1'b0;
    trigger = 1'b0;
    trig_type = 2'd0;
    acq_ready = 1'b1;
    readout_done = 1'b0;
    readout_size = '0;
    rec_ready = 1'b1;
    m_trig_num = 1;
    m_event_cnt = 1;
    m_block = '0;
    m_chan_en = '0;
    m_thres = 0;
    m_ovf = '0;
    exp_pass = 1'b0;
    have_ts = 1'b0;
    acq_pulses = 0;
    exp_pulses = 0;
    for (int i = 0; i < `NUM_CHAN; i++) begin
      m_stored[i] = 0;
      m_burst[i] = 0;
      m_wfm[i] = 0;
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    compare("outputs after reset", 8'd0, {acq_trigger, rec_valid, awready, wready,
                                          bvalid, arready, rvalid, error_trig_rate});

    // 1 register readback
    val = $urandom();
    write_reg(`ADDR_CTRL, val);
    axi_read(`ADDR_CTRL, rd);
    compare("ctrl readback", val, rd);
    val = $urandom();
    write_reg(`ADDR_THRES, val);
    axi_read(`ADDR_THRES, rd);
    compare("threshold readback", val, rd);
    for (int i = 0; i < `NUM_CHAN; i++) begin
      val = $urandom() & 32'h7f_ffff;
      write_reg(8'(`ADDR_BURST0 + 4 * i), val);
      axi_read(8'(`ADDR_BURST0 + 4 * i), rd);
      compare("burst count readback", val, rd);
      val = $urandom() & 32'hfff;
      write_reg(8'(`ADDR_WFM0 + 4 * i), val);
      axi_read(8'(`ADDR_WFM0 + 4 * i), rd);
      compare("waveform count readback", val, rd);
    end

    // 2 accepted triggers, small acquisitions on all channels
    write_reg(`ADDR_CTRL, 32'h0000_1f00);
    write_reg(`ADDR_THRES, 32'hffff_ffff);
    for (int i = 0; i < `NUM_CHAN; i++) begin
      write_reg(8'(`ADDR_BURST0 + 4 * i), 10 + i);
      write_reg(8'(`ADDR_WFM0 + 4 * i), 1);
    end
    repeat (12) fire_trigger(2'($urandom_range(0, 3)), 1'b1);
    wait_drained();

    // 3 type 2 blocked
    write_reg(`ADDR_CTRL, 32'h0000_1f04);
    fire_trigger(2'd2, 1'b1);
    repeat (8) fire_trigger(2'($urandom_range(0, 3)), 1'b1);
    fire_trigger(2'd2, 1'b1);
    wait_drained();

    // 4 channel 0 fills up, about 2M bursts per trigger
    write_reg(`ADDR_CTRL, 32'h0000_0100);
    write_reg(`ADDR_BURST0, 999999);
    write_reg(`ADDR_WFM0, 2);
    write_reg(`ADDR_THRES, 5000000);
    k = 0;
    while (!model_full() && k < 8) begin
      fire_trigger(2'd0, 1'b1);
      wait_idle();
      axi_read(`ADDR_STATUS, rd);
      compare("warning status bit", model_warning(), rd[4]);
      compare("warning output", model_warning(), ddr3_overflow_warning);
      k++;
    end
    repeat (2) fire_trigger(2'($urandom_range(0, 3)), 1'b1);  // empty events now
    wait_idle();
    axi_read(`ADDR_OVF_CNT, rd);
    compare("overflow count", m_ovf, rd);
    pulse_readout(22'd2000002);
    @(negedge clk);
    compare("warning output after readout", model_warning(), ddr3_overflow_warning);
    fire_trigger(2'd1, 1'b1);
    wait_drained();

    // 5 FIFO backpressure and renumbering
    write_reg(`ADDR_CTRL, 32'h0);
    wait_idle();
    @(posedge clk);
    reset_trig_num <= 1'b1;
    @(posedge clk);
    reset_trig_num <= 1'b0;
    m_trig_num = 1;
    m_event_cnt = 1;
    axi_read(`ADDR_TRIG_NUM, rd);
    compare("trig_num after reset_trig_num", 1, rd);
    rec_ready <= 1'b0;
    repeat (`FIFO_DEPTH + 1) fire_trigger(2'($urandom_range(0, 3)), 1'b1);  // last one stalls
    repeat (10) @(posedge clk);
    rec_ready <= 1'b1;
    wait_drained();

    // 6 trigger while the channels are busy
    wait_idle();
    acq_ready <= 1'b0;
    fire_trigger(2'd0, 1'b0);
    do @(negedge clk); while (!error_trig_rate);
    axi_read(`ADDR_STATUS, rd);
    compare("status error bit", 1'b1, rd[5]);
    compare("status state", 4'(st_error), rd[3:0]);
    @(posedge clk);
    acq_ready <= 1'b1;
    repeat (3) fire_trigger(2'($urandom_range(0, 3)), 1'b0);  // ignored in error
    repeat (20) @(posedge clk);
    compare("acq_trigger pulse count", exp_pulses, acq_pulses);

    if (exp_q.size() != 0) begin
      report_failure("expected records never came out");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// ==== source/ttc_trigger_top.sv ====
// ttc trigger subsystem top: registers, trigger receiver, ddr3 occupancy, record FIFO
`include "ttc_cfg.svh"

module ttc_trigger_top (
  input  logic               clk,
  input  logic               reset,
  // axi4-lite register port
  input  logic [`AXI_AW-1:0] awaddr,
  input  logic               awvalid,
  output logic               awready,
  input  logic [31:0]        wdata,
  input  logic               wvalid,
  output logic               wready,
  output logic [1:0]         bresp,
  output logic               bvalid,
  input  logic               bready,
  input  logic [`AXI_AW-1:0] araddr,
  input  logic               arvalid,
  output logic               arready,
  output logic [31:0]        rdata,
  output logic [1:0]         rresp,
  output logic               rvalid,
  input  logic               rready,
  // ttc side
  input  logic               reset_trig_num,
  input  logic               reset_trig_timestamp,
  input  logic               trigger,
  input  logic [1:0]         trig_type,
  // acquisition controller
  input  logic               acq_ready,
  output logic               acq_trigger,
  output logic [1:0]         acq_trig_type,
  output logic [`TRIG_W-1:0] acq_trig_num,
  // readout engine
  input  logic               readout_done,
  input  logic [`RO_W-1:0]   readout_size,
  // records to the trigger processor
  output logic               rec_valid,
  input  logic               rec_ready,
  output logic [127:0]       rec_data,
  output logic               error_trig_rate,
  output logic               ddr3_overflow_warning
);
  import ttc_pkg::*;

  ttc_state_t         state;
  trig_record_t       push_data;
  logic               push_valid;
  logic               push_ready;
  logic               ddr3_full;
  logic [`TRIG_W-1:0] trig_num;
  logic [31:0]        ddr3_overflow_count;

  ttc_cfg_if cfg_if ();

  ttc_csr_axil u_csr (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .cfg                   (cfg_if.regs),
    .trig_num, .ddr3_overflow_count, .state, .ddr3_overflow_warning, .error_trig_rate
  );

  ddr3_occupancy u_occ (
    .clk, .reset,
    .cfg                   (cfg_if.occ),
    .acq_trigger, .readout_done, .readout_size,
    .ddr3_full, .ddr3_overflow_warning
  );

  ttc_trigger_receiver u_rcv (
    .clk, .reset, .reset_trig_num, .reset_trig_timestamp, .trigger, .trig_type,
    .cfg                   (cfg_if.rcv),
    .acq_ready, .ddr3_full, .acq_trigger, .acq_trig_type, .acq_trig_num,
    .push_valid, .push_ready, .push_data,
    .state, .trig_num, .ddr3_overflow_count, .error_trig_rate
  );

  trig_info_fifo #(.DEPTH(`FIFO_DEPTH)) u_fifo (
    .clk, .reset,
    .push_valid, .push_ready, .push_data,
    .pop_valid             (rec_valid),
    .pop_ready             (rec_ready),
    .pop_data              (rec_data)
  );

endmodule

// ==== source/trig_info_fifo.sv ====
// synchronous FIFO queueing trigger records for the trigger processor
module trig_info_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push_valid,
  output logic                  push_ready,
  input  ttc_pkg::trig_record_t push_data,
  output logic                  pop_valid,
  input  logic                  pop_ready,
  output ttc_pkg::trig_record_t pop_data
);
  import ttc_pkg::*;

  localparam int AW = $clog2(DEPTH);

  trig_record_t  mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;    // entries held
  logic          do_push;
  logic          do_pop;

  assign push_ready = (count != DEPTH);  // not full
  assign pop_valid  = (count != 0);      // not empty
  assign do_push    = push_valid & push_ready;
  assign do_pop     = pop_valid & pop_ready;
  assign pop_data   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none, or both at once
      endcase
    end
  end

endmodule

// ==== source/ttc_trigger_receiver.sv ====
// ttc trigger receiver FSM: passes or blocks triggers and builds trigger records
`include "ttc_cfg.svh"

module ttc_trigger_receiver (
  input  logic                  clk,                   // 40 MHz ttc clock
  input  logic                  reset,
  input  logic                  reset_trig_num,        // ttc channel b resets
  input  logic                  reset_trig_timestamp,
  input  logic                  trigger,
  input  logic [1:0]            trig_type,             // muon fill, laser, pedestal
  ttc_cfg_if.rcv                cfg,
  input  logic                  acq_ready,             // channels can take a trigger
  input  logic                  ddr3_full,
  output logic                  acq_trigger,
  output logic [1:0]            acq_trig_type,
  output logic [`TRIG_W-1:0]    acq_trig_num,
  output logic                  push_valid,
  input  logic                  push_ready,
  output ttc_pkg::trig_record_t push_data,
  output ttc_pkg::ttc_state_t   state,
  output logic [`TRIG_W-1:0]    trig_num,              // next trigger number
  output logic [31:0]           ddr3_overflow_count,   // triggers refused for space
  output logic                  error_trig_rate
);
  import ttc_pkg::*;

  logic               accept;          // trigger taken in idle
  logic               blocked;         // type masked in trig_settings
  logic [`TRIG_W-1:0] event_cnt;       // accepted events, starts at 1
  logic [`TS_W-1:0]   ts_cnt;          // free-running clock count
  logic [`TS_W-1:0]   trig_timestamp;  // ts_cnt latched at trigger

  assign accept          = (state == st_idle) & trigger;
  assign blocked         = cfg.ctrl.f.trig_settings[acq_trig_type];
  assign acq_trigger     = (state == st_send_trigger) & acq_ready & ~blocked & ~ddr3_full;
  assign error_trig_rate = (state == st_error);

  always_ff @(posedge clk) begin
    if (reset) begin
      state               <= st_idle;
      push_valid          <= 1'b0;
      acq_trig_type       <= 2'd0;
      ddr3_overflow_count <= '0;
    end else begin
      unique case (state)
        st_idle: begin
          if (trigger) begin
            acq_trig_type <= trig_type;
            state         <= st_send_trigger;
          end
        end
        st_send_trigger: begin
          if (!acq_ready) begin
            state <= st_error;  // trigger came while still acquiring
          end else begin
            if (!blocked && ddr3_full)
              ddr3_overflow_count <= ddr3_overflow_count + 1;
            push_valid <= 1'b1;  // record goes out next cycle
            state      <= st_store_trig_info;
          end
        end
        st_store_trig_info: begin
          if (push_ready) begin
            push_valid <= 1'b0;
            state      <= st_idle;
          end
        end
        st_error: state <= st_error;
        default:  state <= st_error;
      endcase
    end
  end

  // numbering restarts at 1
  always_ff @(posedge clk) begin
    if (reset || reset_trig_num) begin
      trig_num     <= 1;
      acq_trig_num <= 1;
      event_cnt    <= 1;
    end else begin
      if (accept) begin
        acq_trig_num <= trig_num;
        trig_num     <= trig_num + 1;
      end
      if (acq_trigger)
        event_cnt <= event_cnt + 1;  // passed triggers only
    end
  end

  always_ff @(posedge clk) begin
    if (reset || reset_trig_timestamp) begin
      ts_cnt         <= '0;
      trig_timestamp <= '0;
    end else begin
      ts_cnt <= ts_cnt + 1;
      if (accept)
        trig_timestamp <= ts_cnt;
    end
  end

  // record built while the decision is made
  always_ff @(posedge clk) begin
    if (state == st_send_trigger) begin
      push_data.reserved    <= '0;
      push_data.empty_event <= blocked | ddr3_full;
      push_data.trig_type   <= acq_trig_type;
      push_data.event_cnt   <= event_cnt;  // count before this event
      push_data.trig_num    <= acq_trig_num;
      push_data.timestamp   <= trig_timestamp;
    end
  end

endmodule

// ==== source/ddr3_occupancy.sv ====
// ddr3 occupancy tracker: stored bursts per channel, full check and overflow warning
`include "ttc_cfg.svh"

module ddr3_occupancy (
  input  logic             clk,
  input  logic             reset,
  ttc_cfg_if.occ           cfg,
  input  logic             acq_trigger,   // acquisition started
  input  logic             readout_done,  // one event left ddr3
  input  logic [`RO_W-1:0] readout_size,  // bursts freed by it
  output logic             ddr3_full,
  output logic             ddr3_overflow_warning
);
  localparam int SIZE_W = `BURST_W + `WFM_W + 1;  // full product, no truncation

  logic [`NUM_CHAN-1:0][SIZE_W-1:0] acq_size;  // bursts one trigger writes
  logic [`NUM_CHAN-1:0][`OCC_W-1:0] stored;    // bursts still waiting for readout
  logic [`NUM_CHAN-1:0]             chan_full;
  logic [`NUM_CHAN-1:0]             chan_warn;

  always_comb begin
    for (int i = 0; i < `NUM_CHAN; i++) begin
      // waveforms times (bursts + header), plus two trailer bursts
      acq_size[i]  = (cfg.burst_count[i] + 1) * cfg.wfm_count[i] + 2;
      // stored never exceeds capacity, so no underflow here
      chan_full[i] = cfg.ctrl.f.chan_en[i] & ((`DDR3_BURSTS - stored[i]) < acq_size[i]);
      chan_warn[i] = stored[i] > cfg.thres_ddr3_overflow;
    end
  end

  assign ddr3_full             = |chan_full;
  assign ddr3_overflow_warning = |chan_warn;  // any channel, enabled or not

  always_ff @(posedge clk) begin
    if (reset) begin
      stored <= '0;
    end else begin
      for (int i = 0; i < `NUM_CHAN; i++) begin
        if (cfg.ctrl.f.chan_en[i]) begin
          if (acq_trigger && !readout_done)
            stored[i] <= stored[i] + acq_size[i][`OCC_W-1:0];  // fits, trigger was not full
          else if (readout_done && !acq_trigger)
            stored[i] <= stored[i] - readout_size;
          // both at once: counters hold
        end
      end
    end
  end

endmodule

// ==== source/ttc_csr_axil.sv ====
// axi4-lite register block: trigger configuration registers and status readback
`include "ttc_cfg.svh"

module ttc_csr_axil (
  input  logic                clk,
  input  logic                reset,
  // write address and data
  input  logic [`AXI_AW-1:0]  awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [31:0]         wdata,
  input  logic                wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  // read
  input  logic [`AXI_AW-1:0]  araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [31:0]         rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready,
  ttc_cfg_if.regs             cfg,
  // status sources
  input  logic [`TRIG_W-1:0]  trig_num,
  input  logic [31:0]         ddr3_overflow_count,
  input  ttc_pkg::ttc_state_t state,
  input  logic                ddr3_overflow_warning,
  input  logic                error_trig_rate
);
  logic        busy;      // one access in flight
  logic        wr_start;
  logic        rd_start;
  logic [31:0] rd_word;

  assign busy     = awready | bvalid | arready | rvalid;
  assign wr_start = awvalid & wvalid & ~busy;  // address and data together
  assign rd_start = arvalid & ~busy & ~(awvalid & wvalid);  // write wins a tie
  assign bresp    = 2'b00;  // always OKAY
  assign rresp    = 2'b00;

  // handshake flags
  always_ff @(posedge clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= wr_start;  // single-cycle pulses
      wready  <= wr_start;
      arready <= rd_start;
      if (awready)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
      if (arready)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  // register writes on the handshake cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.ctrl.raw            <= '0;
      cfg.thres_ddr3_overflow <= '0;
      cfg.burst_count         <= '0;
      cfg.wfm_count           <= '0;
    end else if (awready) begin
      if (awaddr == `ADDR_CTRL)
        cfg.ctrl.raw <= wdata;
      if (awaddr == `ADDR_THRES)
        cfg.thres_ddr3_overflow <= wdata;
      for (int i = 0; i < `NUM_CHAN; i++) begin
        if (awaddr == `ADDR_BURST0 + 4 * i)
          cfg.burst_count[i] <= wdata[`BURST_W-1:0];
        if (awaddr == `ADDR_WFM0 + 4 * i)
          cfg.wfm_count[i] <= wdata[`WFM_W-1:0];
      end
    end
  end

  // read mux, unmapped reads return zero
  always_comb begin
    rd_word = '0;
    case (araddr)
      `ADDR_CTRL:     rd_word = cfg.ctrl.raw;
      `ADDR_THRES:    rd_word = cfg.thres_ddr3_overflow;
      `ADDR_TRIG_NUM: rd_word = 32'(trig_num);
      `ADDR_OVF_CNT:  rd_word = ddr3_overflow_count;
      `ADDR_STATUS:   rd_word = {26'd0, error_trig_rate, ddr3_overflow_warning, state};
      default:        rd_word = '0;
    endcase
    for (int i = 0; i < `NUM_CHAN; i++) begin
      if (araddr == `ADDR_BURST0 + 4 * i)
        rd_word = 32'(cfg.burst_count[i]);
      if (araddr == `ADDR_WFM0 + 4 * i)
        rd_word = 32'(cfg.wfm_count[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (arready)
      rdata <= rd_word;  // held with rvalid
  end

endmodule

// ==== source/ttc_cfg_if.sv ====
// configuration bundle from the register block to the receiver and occupancy tracker
`include "ttc_cfg.svh"

interface ttc_cfg_if;
  import ttc_pkg::*;

  ctrl_reg_t                             ctrl;
  logic [31:0]                           thres_ddr3_overflow;  // warning level in bursts
  logic [`NUM_CHAN-1:0][`BURST_W-1:0]    burst_count;  // bursts per waveform
  logic [`NUM_CHAN-1:0][`WFM_W-1:0]      wfm_count;    // waveforms per acquisition

  modport regs (
    output ctrl, thres_ddr3_overflow, burst_count, wfm_count
  );

  modport rcv (
    input ctrl
  );

  modport occ (
    input ctrl, thres_ddr3_overflow, burst_count, wfm_count
  );

endinterface

// ==== source/ttc_pkg.sv ====
// shared types for the ttc trigger subsystem: FSM state, trigger record, control word
`include "ttc_cfg.svh"

package ttc_pkg;

  // one-hot receiver state
  typedef enum logic [3:0] {
    st_idle            = 4'b0001,
    st_send_trigger    = 4'b0010,
    st_store_trig_info = 4'b0100,
    st_error           = 4'b1000  // hard error, left only by reset
  } ttc_state_t;

  // 128-bit word for the trigger processor
  typedef struct packed {
    logic [32:0]        reserved;     // always zero
    logic               empty_event;  // trigger answered without data
    logic [1:0]         trig_type;
    logic [`TRIG_W-1:0] event_cnt;    // accepted events, starts at 1
    logic [`TRIG_W-1:0] trig_num;     // all triggers, starts at 1
    logic [`TS_W-1:0]   timestamp;
  } trig_record_t;

  // control register, stored raw and decoded as fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [31-8-`NUM_CHAN:0] spare;
      logic [`NUM_CHAN-1:0]    chan_en;        // enabled channels
      logic [7:0]              trig_settings;  // set bit blocks that type
    } f;
  } ctrl_reg_t;

endpackage

// ==== source/ttc_cfg.svh ====
// ttc trigger subsystem constants: sizes, widths and register map
`ifndef TTC_CFG_SVH
`define TTC_CFG_SVH

`define NUM_CHAN    5        // digitizer channels
`define BURST_W     23       // burst count per waveform
`define WFM_W       12       // waveforms per fill
`define RO_W        22       // readout size in bursts
`define OCC_W       24       // stored-burst counter, wide enough for full capacity
`define TRIG_W      24       // trigger number and event count
`define TS_W        44       // timestamp in ttc clocks
`define AXI_AW      8
`define DDR3_BURSTS 8388608  // capacity per channel in bursts
`define FIFO_DEPTH  16

// register byte addresses
`define ADDR_CTRL     8'h00
`define ADDR_THRES    8'h04
`define ADDR_BURST0   8'h10  // one word per channel
`define ADDR_WFM0     8'h30  // one word per channel
`define ADDR_TRIG_NUM 8'h50
`define ADDR_OVF_CNT  8'h54
`define ADDR_STATUS   8'h58

`endif
